//--- flist.f
pq_pkg.sv
pq_occupancy.sv
pq_issue_ctrl.sv
pq_level.sv
pq_heap_top.sv
pq_props.sv
pq_tb.sv

//--- Bender.yml
package:
  name: pq_heap

sources:
  - files:
      - pq_pkg.sv
      - pq_occupancy.sv
      - pq_issue_ctrl.sv
      - pq_level.sv
      - pq_heap_top.sv
  - target: simulation
    files:
      - pq_props.sv
      - pq_tb.sv

//--- pq_tb.sv
`timescale 1ns/10ps

module pq_tb;

   import pq_pkg::*;

   localparam int DEPTH      = 5;
   localparam int CAP        = (1 << DEPTH) - 1;
   localparam int N_INS      = 20;
   localparam int N_MIX      = 400;
   localparam int NUM_OPS    = 2 * N_INS + 2 * CAP + 2 + N_MIX;
   localparam int TIMEOUT_NS = (NUM_OPS + 50) * 2 * 40;

   logic       clk;
   logic       rst_n;
   logic       enq;
   logic       deq;
   key_t       key_in;
   key_t       min_key;
   logic       ready;
   pq_status_t status;

   key_t   model[$];   // Sorted, smallest first
   logic   settle;     // Model of the enq spacing cycle
   integer seed;
   int     errors;
   int     checks;
   int     sel;
   key_t   rkey;

   pq_heap_top #(.DEPTH(DEPTH)) u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .enq     (enq),
      .deq     (deq),
      .key_in  (key_in),
      .min_key (min_key),
      .ready   (ready),
      .status  (status)
   );

   always #20 clk = ~clk;

   task automatic check_key(input string name, input key_t exp, input key_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic model_insert(input key_t k);
      int pos;
      pos = 0;
      while (pos < model.size() && model[pos] <= k) begin
         pos++;
      end
      model.insert(pos, k);
   endtask

   task automatic check_outputs(input string name, input logic exp_drop);
      check_count($sformatf("%s count", name), cnt_t'(model.size()), status.count);
      check_flag($sformatf("%s full", name), model.size() == CAP, status.full);
      check_flag($sformatf("%s empty", name), model.size() == 0, status.empty);
      check_flag($sformatf("%s drop", name), exp_drop, status.drop);
      if (model.size() > 0) begin
         check_key($sformatf("%s min", name), model[0], min_key);
      end
   endtask

   // Called at a falling edge, returns at the next one
   task automatic apply(input logic e, input logic d, input key_t k, input string name);
      logic exp_drop;
      logic next_settle;
      enq         = e;
      deq         = d;
      key_in      = k;
      exp_drop    = 1'b0;
      next_settle = 1'b0;
      if (!settle) begin
         if (e && !d && model.size() < CAP) begin
            model_insert(k);
            next_settle = 1'b1;   // Accepted enq
         end else if (d && !e && model.size() > 0) begin
            void'(model.pop_front());
         end else if (e || d) begin
            exp_drop = 1'b1;   // Collision, full or empty
         end
      end
      #1;
      check_flag($sformatf("%s ready", name), !settle && !next_settle, ready);
      @(negedge clk);
      settle = next_settle;
      check_outputs(name, exp_drop);
   endtask

   initial begin
      clk    = 1'b0;
      rst_n  = 1'b0;
      enq    = 1'b0;
      deq    = 1'b0;
      key_in = '0;
      settle = 1'b0;
      errors = 0;
      checks = 0;
      seed   = 32'h4dba;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_count("reset count", '0, status.count);
      check_flag("reset empty", 1'b1, status.empty);
      check_flag("reset full", 1'b0, status.full);
      check_flag("reset drop", 1'b0, status.drop);
      check_flag("reset ready", 1'b1, ready);

      for (int i = 0; i < N_INS; i++) begin
         apply(1'b1, 1'b0, key_t'($random(seed)), "insert");
         apply(1'b0, 1'b0, '0, "insert gap");
      end
      while (model.size() > 0) begin
         apply(1'b0, 1'b1, '0, "drain");   // Back to back deq
      end

      for (int i = 0; i < CAP; i++) begin
         apply(1'b1, 1'b0, key_t'($random(seed)) | key_t'(1), "fill");
         apply(1'b0, 1'b0, '0, "fill gap");
      end
      check_flag("fill full", 1'b1, status.full);
      apply(1'b1, 1'b0, '0, "enq when full");   // Key 0 would become the new min
      while (model.size() > 0) begin
         apply(1'b0, 1'b1, '0, "empty out");
      end
      apply(1'b0, 1'b1, '0, "deq when empty");
      apply(1'b0, 1'b0, '0, "after drop");

      for (int i = 0; i < N_MIX; i++) begin
         sel  = $unsigned($random(seed)) % 8;
         rkey = key_t'($random(seed)) & key_t'(16'h00ff);   // Narrow keys give duplicates
         case (sel)
            0, 1, 2: apply(1'b1, 1'b0, rkey, "mix enq");
            3, 4, 5: apply(1'b0, 1'b1, rkey, "mix deq");
            6:       apply(1'b1, 1'b1, rkey, "mix both");
            default: apply(1'b0, 1'b0, rkey, "mix idle");
         endcase
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Run timed out after %0d ns before all operations completed", TIMEOUT_NS);
      $display("Something failed");
      $finish;
   end

endmodule

//--- pq_props.sv
`timescale 1ns/10ps

module pq_props (
   input logic clk,
   input logic rst_n,
   input logic enq,
   input logic deq,
   input logic full,
   input logic ready,
   input logic inc,
   input logic dec,
   input logic drop
);

   // Accepted enq always costs a settle cycle
   a_settle_after_enq : assert property (@(posedge clk) disable iff (!rst_n)
      inc |=> !ready)
      else $error("ready high in the cycle after an accepted enq");

   a_inc_dec_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(inc && dec))
      else $error("inc and dec high together");

   // Each drop cycle needs its own request seen while ready was high
   a_drop_single : assert property (@(posedge clk) disable iff (!rst_n)
      drop |-> $past(ready && (enq || deq)))
      else $error("drop without a request under ready in the previous cycle");

   a_no_inc_full : assert property (@(posedge clk) disable iff (!rst_n)
      !(inc && full))
      else $error("inc while the queue is full");

endmodule

bind pq_issue_ctrl pq_props u_props (
   .clk   (clk),
   .rst_n (rst_n),
   .enq   (enq),
   .deq   (deq),
   .full  (full),
   .ready (ready),
   .inc   (inc),
   .dec   (dec),
   .drop  (drop)
);

//--- pq_heap_top.sv
`timescale 1ns/10ps

module pq_heap_top #(
   parameter int DEPTH = 5
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               enq,
   input  logic               deq,
   input  pq_pkg::key_t       key_in,
   output pq_pkg::key_t       min_key,
   output logic               ready,
   output pq_pkg::pq_status_t status
);

   import pq_pkg::*;

   pq_req_t     req  [DEPTH];
   node_idx_t   pidx [DEPTH];
   child_view_t view [DEPTH];
   key_t        head [DEPTH];
   cnt_t        count;
   logic        full;
   logic        empty;
   logic        inc;
   logic        dec;
   logic        drop;

   pq_issue_ctrl #(.DEPTH(DEPTH)) u_issue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (enq),
      .deq      (deq),
      .key_in   (key_in),
      .full     (full),
      .empty    (empty),
      .ready    (ready),
      .root_req (req[0]),
      .inc      (inc),
      .dec      (dec),
      .drop     (drop)
   );

   pq_occupancy #(.DEPTH(DEPTH)) u_occ (
      .clk   (clk),
      .rst_n (rst_n),
      .inc   (inc),
      .dec   (dec),
      .count (count),
      .full  (full),
      .empty (empty)
   );

   assign pidx[0] = '0;   // Nothing peeks into the root

   for (genvar k = 0; k < DEPTH; k++) begin : g_level
      if (k < DEPTH - 1) begin : g_mid
         pq_level #(.LEVEL(k), .DEPTH(DEPTH)) u_level (
            .clk        (clk),
            .rst_n      (rst_n),
            .up_req     (req[k]),
            .down_req   (req[k+1]),
            .child_idx  (pidx[k+1]),
            .child_view (view[k+1]),
            .peek_idx   (pidx[k]),
            .peek_view  (view[k]),
            .head_key   (head[k])
         );
      end else begin : g_last
         pq_level #(.LEVEL(k), .DEPTH(DEPTH)) u_level (
            .clk        (clk),
            .rst_n      (rst_n),
            .up_req     (req[k]),
            .down_req   (),
            .child_idx  (),
            .child_view (),
            .peek_idx   (pidx[k]),
            .peek_view  (view[k]),
            .head_key   (head[k])
         );
      end
   end

   assign min_key = head[0];
   assign status  = '{count: count, full: full, empty: empty, drop: drop};

endmodule

//--- pq_level.sv
`timescale 1ns/10ps

module pq_level #(
   parameter int LEVEL = 0,
   parameter int DEPTH = 5
) (
   input  logic                clk,
   input  logic                rst_n,
   input  pq_pkg::pq_req_t     up_req,
   output pq_pkg::pq_req_t     down_req,
   output pq_pkg::node_idx_t   child_idx,
   input  pq_pkg::child_view_t child_view,
   input  pq_pkg::node_idx_t   peek_idx,
   output pq_pkg::child_view_t peek_view,
   output pq_pkg::key_t        head_key
);

   import pq_pkg::*;

   localparam int   IDX_W     = $bits(node_idx_t);
   localparam int   NODES     = 1 << LEVEL;
   localparam int   SLOTS     = (NODES < 2) ? 2 : NODES;   // Root keeps a spare right slot
   localparam int   SW        = $clog2(SLOTS);
   localparam bit   HAS_CHILD = (LEVEL < DEPTH - 1);
   localparam cnt_t SUB_CAP   = cnt_t'((1 << (DEPTH - LEVEL)) - 1);

   key_t key_q [SLOTS];
   logic vld_q [SLOTS];
   cnt_t cap_q [SLOTS];   // Free slots in the subtree under each node

   logic [SW-1:0] node;
   key_t          cur_key;
   logic          cur_vld;
   cnt_t          cur_cap;
   child_view_t   view;

   key_t          nxt_key;
   logic          nxt_vld;
   cnt_t          nxt_cap;
   logic          side;
   pq_req_t       nxt_req;

   node_idx_t     l_idx;
   node_idx_t     r_idx;
   logic [SW-1:0] l_slot;
   logic [SW-1:0] r_slot;
   logic          l_fwd;
   logic          r_fwd;
   cnt_t          l_cap;

   assign node      = up_req.idx[SW-1:0];
   assign cur_key   = key_q[node];
   assign cur_vld   = vld_q[node];
   assign cur_cap   = cap_q[node];
   assign view      = HAS_CHILD ? child_view : '0;   // Bottom level has no children
   assign child_idx = up_req.idx;   // Pair below this node
   assign head_key  = key_q[0];

   // Sift step for the node addressed by up_req
   always_comb begin
      nxt_key     = cur_key;
      nxt_vld     = cur_vld;
      nxt_cap     = cur_cap;
      side        = 1'b0;
      nxt_req.op  = op_nop;
      nxt_req.key = up_req.key;
      case (up_req.op)
         op_enq: begin
            nxt_vld = 1'b1;
            nxt_cap = cur_cap - cnt_t'(1);
            side    = !view.left_room;   // Fill left while it has room
            if (cur_vld) begin
               nxt_req.op = op_enq;
               if (up_req.key < cur_key) begin
                  nxt_key     = up_req.key;
                  nxt_req.key = cur_key;   // Larger key sinks
               end
            end else begin
               nxt_key = up_req.key;
            end
         end
         op_deq: begin
            nxt_cap = cur_cap + cnt_t'(1);
            if (view.left_vld || view.right_vld) begin
               side       = !view.left_vld ||
                            (view.right_vld && (view.right_key < view.left_key));
               nxt_key    = side ? view.right_key : view.left_key;
               nxt_req.op = op_deq;   // Refill the child that moved up
            end else begin
               nxt_vld = 1'b0;   // Leaf empties, op ends here
            end
         end
         default: ;
      endcase
      nxt_req.idx = {up_req.idx[IDX_W-2:0], side};
      if (!HAS_CHILD) begin
         nxt_req.op = op_nop;
      end
   end

   // Pair view for the parent level
   assign l_idx  = {peek_idx[IDX_W-2:0], 1'b0};
   assign r_idx  = l_idx | node_idx_t'(1);
   assign l_slot = l_idx[SW-1:0];
   assign r_slot = r_idx[SW-1:0];

   // A node being rewritten this cycle shows its new contents
   assign l_fwd  = (l_slot == node);
   assign r_fwd  = (r_slot == node);
   assign l_cap  = l_fwd ? nxt_cap : cap_q[l_slot];

   always_comb begin
      peek_view.left_key  = l_fwd ? nxt_key : key_q[l_slot];
      peek_view.right_key = r_fwd ? nxt_key : key_q[r_slot];
      peek_view.left_vld  = l_fwd ? nxt_vld : vld_q[l_slot];
      peek_view.right_vld = r_fwd ? nxt_vld : vld_q[r_slot];
      peek_view.left_room = (l_cap != '0);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < SLOTS; i++) begin
            vld_q[i] <= 1'b0;
            cap_q[i] <= SUB_CAP;
         end
         down_req <= '0;
      end else begin
         vld_q[node] <= nxt_vld;
         cap_q[node] <= nxt_cap;
         down_req    <= nxt_req;
      end
   end

   always_ff @(posedge clk) begin
      key_q[node] <= nxt_key;
   end

endmodule

//--- pq_issue_ctrl.sv
`timescale 1ns/10ps

module pq_issue_ctrl #(
   parameter int DEPTH = 5
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            enq,
   input  logic            deq,
   input  pq_pkg::key_t    key_in,
   input  logic            full,
   input  logic            empty,
   output logic            ready,
   output pq_pkg::pq_req_t root_req,
   output logic            inc,
   output logic            dec,
   output logic            drop
);

   import pq_pkg::*;

   typedef enum logic {
      st_open,
      st_settle
   } state_e;

   state_e state;
   state_e state_nxt;
   logic   open;
   logic   any_req;
   logic   take_enq;
   logic   take_deq;

   // Node index width only covers up to MAX_DEPTH levels
   if (DEPTH < 1 || DEPTH > MAX_DEPTH) begin : g_bad_depth
      $error("DEPTH %0d is outside 1 to %0d", DEPTH, MAX_DEPTH);
   end

   assign open     = (state == st_open);
   assign any_req  = open && (enq || deq);
   assign take_enq = open && enq && !deq && !full;
   assign take_deq = open && deq && !enq && !empty;

   assign ready = open && !take_enq;   // Enq cycle already closes the window
   assign inc   = take_enq;
   assign dec   = take_deq;

   always_comb begin
      root_req.op  = op_nop;
      root_req.key = key_in;
      root_req.idx = '0;   // Single node at level 0
      if (take_enq) begin
         root_req.op = op_enq;
      end else if (take_deq) begin
         root_req.op = op_deq;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_open:   state_nxt = take_enq ? st_settle : st_open;
         st_settle: state_nxt = st_open;   // Second cycle of enq spacing
         default:   state_nxt = st_open;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_open;
         drop  <= 1'b0;
      end else begin
         state <= state_nxt;
         drop  <= any_req && !take_enq && !take_deq;   // Collision, full or empty
      end
   end

endmodule

//--- pq_occupancy.sv
`timescale 1ns/10ps

module pq_occupancy #(
   parameter int DEPTH = 5
) (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         inc,
   input  logic         dec,
   output pq_pkg::cnt_t count,
   output logic         full,
   output logic         empty
);

   import pq_pkg::*;

   localparam cnt_t MAX_CNT = cnt_t'((1 << DEPTH) - 1);

   // inc and dec are exclusive by construction of the issue FSM
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
      end else if (inc) begin
         count <= count + cnt_t'(1);
      end else if (dec) begin
         count <= count - cnt_t'(1);
      end
   end

   assign full  = (count == MAX_CNT);
   assign empty = (count == '0);

endmodule

//--- pq_pkg.sv
package pq_pkg;

   parameter int KEY_W     = 16;
   parameter int MAX_DEPTH = 8;

   typedef logic [KEY_W-1:0] key_t;
   typedef logic [7:0]       node_idx_t;   // Covers the widest level at MAX_DEPTH
   typedef logic [8:0]       cnt_t;

   typedef enum logic [1:0] {
      op_nop,
      op_enq,
      op_deq
   } pq_op_e;

   typedef struct packed {
      pq_op_e    op;
      key_t      key;
      node_idx_t idx;   // Node addressed in the receiving level
   } pq_req_t;

   typedef struct packed {
      key_t left_key;
      key_t right_key;
      logic left_vld;
      logic right_vld;
      logic left_room;   // Free slot somewhere in left subtree
   } child_view_t;

   typedef struct packed {
      cnt_t count;
      logic full;
      logic empty;
      logic drop;
   } pq_status_t;

endpackage
